//--- logic/timekeeper_pkg.sv
/*
 * shared settings addresses, queue sizing and command types for the timekeeper.
 * the settings bus addresses are absolute; there is no base offset.
 */

`default_nettype none

package timekeeper_pkg;

   // ==================================================
   // settings bus register map
   // ==================================================

   // upper 32 bits of the time to load.
   localparam logic [7:0] TIME_HI_ADDR   = 8'd0;
   // lower 32 bits of the time to load.
   localparam logic [7:0] TIME_LO_ADDR   = 8'd1;
   // a write here queues a set-time command.
   localparam logic [7:0] TIME_CTRL_ADDR = 8'd2;

   // ==================================================
   // command queue sizing
   // ==================================================

   // number of pending commands held.
   localparam int CMD_FIFO_DEPTH = 4;
   // pointer width, one entry per code.
   localparam int CMD_PTR_W      = $clog2(CMD_FIFO_DEPTH);
   // count needs one extra bit to reach full.
   localparam int CMD_CNT_W      = CMD_PTR_W + 1;

   // ==================================================
   // types
   // ==================================================

   // when a queued time value takes effect.
   // code 3 is not a mode and never reaches the queue.
   typedef enum logic [1:0] {
      MODE_NOW  = 2'd0,
      MODE_PPS  = 2'd1,
      MODE_SYNC = 2'd2
   } time_mode_e;

   // one settings bus beat, valid when stb is high.
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // one set-time command.
   typedef struct packed {
      time_mode_e  mode;
      logic [63:0] time_value;
   } time_cmd_t;

endpackage

`default_nettype wire

//--- logic/time_settings.sv
/*
 * settings bus decoder for the time registers.
 * write hi and lo before ctrl; a ctrl value of 3 is ignored.
 */

`timescale 1ns/1ns
`default_nettype none

module time_settings (
   input  logic                    clk,
   input  logic                    reset,
   input  timekeeper_pkg::set_bus_t set_bus,
   output timekeeper_pkg::time_cmd_t cmd,
   output logic                    cmd_stb
);

   import timekeeper_pkg::*;

   // registered copy of the bus.
   set_bus_t    bus_q;

   // staged time value.
   logic [31:0] time_hi;
   logic [31:0] time_lo;

   // decoded writes.
   logic        wr_hi;
   logic        wr_lo;
   logic        wr_ctrl;

   // ctrl data carries a real mode.
   logic        mode_ok;

   // ==================================================
   // bus input stage
   // ==================================================

   // flop the bus first so decode sees clean timing.
   // only the strobe needs a reset.
   always_ff @(posedge clk) begin
      bus_q <= set_bus;
      if (reset) begin
         bus_q.stb <= 1'b0;
      end
   end

   // address decode.
   assign wr_hi   = bus_q.stb && (bus_q.addr == TIME_HI_ADDR);
   assign wr_lo   = bus_q.stb && (bus_q.addr == TIME_LO_ADDR);
   assign wr_ctrl = bus_q.stb && (bus_q.addr == TIME_CTRL_ADDR);

   // code 3 is reserved.
   assign mode_ok = (bus_q.data[1:0] != 2'd3);

   // ==================================================
   // time registers
   // ==================================================

   always_ff @(posedge clk) begin
      if (reset) begin
         time_hi <= '0;
         time_lo <= '0;
      end else begin
         if (wr_hi) begin
            time_hi <= bus_q.data;
         end
         if (wr_lo) begin
            time_lo <= bus_q.data;
         end
      end
   end

   // ==================================================
   // command generation
   // ==================================================

   // command payload, held until the next valid ctrl write.
   // takes hi/lo as they stand before this edge.
   always_ff @(posedge clk) begin
      if (wr_ctrl && mode_ok) begin
         cmd.mode       <= time_mode_e'(bus_q.data[1:0]);
         cmd.time_value <= {time_hi, time_lo};
      end
   end

   // one-cycle strobe, lines up with the new payload.
   always_ff @(posedge clk) begin
      if (reset) begin
         cmd_stb <= 1'b0;
      end else begin
         cmd_stb <= wr_ctrl && mode_ok;
      end
   end

endmodule

`default_nettype wire

//--- logic/time_cmd_fifo.sv
/*
 * small queue of set-time commands, no back-pressure on the push side.
 * a push while full is lost and latches overflow until reset.
 */

`timescale 1ns/1ns
`default_nettype none

module time_cmd_fifo (
   input  logic                     clk,
   input  logic                     reset,
   input  timekeeper_pkg::time_cmd_t cmd,
   input  logic                     cmd_stb,
   input  logic                     pop,
   output timekeeper_pkg::time_cmd_t head,
   output logic                     empty,
   output logic                     overflow
);

   import timekeeper_pkg::*;

   // storage.
   time_cmd_t            mem [CMD_FIFO_DEPTH];

   // circular pointers and fill level.
   logic [CMD_PTR_W-1:0] wr_ptr;
   logic [CMD_PTR_W-1:0] rd_ptr;
   logic [CMD_CNT_W-1:0] count;

   logic                 full;
   logic                 push_ok;
   logic                 pop_ok;

   // wrap at the depth, not at the pointer width.
   function automatic logic [CMD_PTR_W-1:0] ptr_inc(input logic [CMD_PTR_W-1:0] ptr);
      if (ptr == CMD_PTR_W'(CMD_FIFO_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // ==================================================
   // status
   // ==================================================

   assign empty = (count == '0);
   assign full  = (count == CMD_CNT_W'(CMD_FIFO_DEPTH));

   // full drops the push even with a pop on the same edge.
   assign push_ok = cmd_stb && !full;
   assign pop_ok  = pop && !empty;

   // head is valid whenever empty is low.
   assign head = mem[rd_ptr];

   // ==================================================
   // storage write
   // ==================================================

   always_ff @(posedge clk) begin
      if (push_ok) begin
         mem[wr_ptr] <= cmd;
      end
   end

   // ==================================================
   // pointers and count
   // ==================================================

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_ok) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop_ok) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         // push and pop together leave the level alone.
         case ({push_ok, pop_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // ==================================================
   // overflow
   // ==================================================

   // sticky, only reset clears it.
   always_ff @(posedge clk) begin
      if (reset) begin
         overflow <= 1'b0;
      end else if (cmd_stb && full) begin
         overflow <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- logic/time_tracker.sv
/*
 * 64-bit sample time counter with queued set-time commands.
 * pps is asynchronous and unfiltered; sync must be a synchronous pulse.
 */

`timescale 1ns/1ns
`default_nettype none

module time_tracker (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     pps,
   input  logic                     sync,
   input  timekeeper_pkg::time_cmd_t head,
   input  logic                     empty,
   output logic                     pop,
   output logic [63:0]              vita_time,
   output logic [63:0]              vita_time_lastpps
);

   import timekeeper_pkg::*;

   // one command in flight at a time.
   typedef enum logic {
      IDLE  = 1'b0,
      ARMED = 1'b1
   } arm_state_e;

   arm_state_e  state;
   logic        armed;

   // command waiting for its event.
   time_cmd_t   cmd_q;

   // pps synchroniser and edge compare.
   logic        pps_meta;
   logic        pps_sync;
   logic        pps_dly;
   logic        pps_edge;

   // load strobe and next counter value.
   logic        time_event;
   logic [63:0] time_next;

   // ==================================================
   // pps edge detection
   // ==================================================

   // two flops to synchronise, a third to compare.
   // a rise sampled at edge p shows as pps_edge for edge p+2.
   always_ff @(posedge clk) begin
      if (reset) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_dly  <= 1'b0;
      end else begin
         pps_meta <= pps;
         pps_sync <= pps_meta;
         pps_dly  <= pps_sync;
      end
   end

   assign pps_edge = pps_sync && !pps_dly;

   // ==================================================
   // command arming
   // ==================================================

   assign armed = (state == ARMED);

   // pull the next command only while nothing is armed.
   assign pop = !armed && !empty;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (!empty) begin
                  state <= ARMED;
               end
            end
            ARMED: begin
               // disarm on the load edge.
               if (time_event) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // payload capture, no reset needed.
   always_ff @(posedge clk) begin
      if (pop) begin
         cmd_q <= head;
      end
   end

   // event for the armed command's mode.
   always_comb begin
      time_event = 1'b0;
      if (armed) begin
         case (cmd_q.mode)
            MODE_NOW:  time_event = 1'b1;
            MODE_PPS:  time_event = pps_edge;
            MODE_SYNC: time_event = sync;
            default:   time_event = 1'b0;
         endcase
      end
   end

   // ==================================================
   // time counter and last-pps capture
   // ==================================================

   // either the loaded value or one more than now.
   assign time_next = time_event ? cmd_q.time_value : vita_time + 64'd1;

   always_ff @(posedge clk) begin
      if (reset) begin
         vita_time <= '0;
      end else begin
         vita_time <= time_next;
      end
   end

   // lastpps matches vita_time after the same edge.
   always_ff @(posedge clk) begin
      if (reset) begin
         vita_time_lastpps <= '0;
      end else if (pps_edge) begin
         vita_time_lastpps <= time_next;
      end
   end

endmodule

`default_nettype wire

//--- logic/timekeeper_top.sv
/*
 * timekeeper top level, settings decode into command queue into tracker.
 * a MODE_NOW load lands four cycles after the ctrl write with an empty queue.
 */

`timescale 1ns/1ns
`default_nettype none

module timekeeper_top (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    pps,
   input  logic                    sync,
   input  timekeeper_pkg::set_bus_t set_bus,
   output logic [63:0]             vita_time,
   output logic [63:0]             vita_time_lastpps,
   output logic                    cmd_overflow
);

   import timekeeper_pkg::*;

   // ==================================================
   // interconnect
   // ==================================================

   // decoder to queue.
   time_cmd_t cmd;
   logic      cmd_stb;

   // queue to tracker.
   time_cmd_t head;
   logic      empty;
   logic      pop;

   // settings bus writes into time regs and commands.
   time_settings settings_i (
      .clk     (clk),
      .reset   (reset),
      .set_bus (set_bus),
      .cmd     (cmd),
      .cmd_stb (cmd_stb)
   );

   // pending commands.
   time_cmd_fifo fifo_i (
      .clk      (clk),
      .reset    (reset),
      .cmd      (cmd),
      .cmd_stb  (cmd_stb),
      .pop      (pop),
      .head     (head),
      .empty    (empty),
      .overflow (cmd_overflow)
   );

   // counter, arming and pps capture.
   time_tracker tracker_i (
      .clk               (clk),
      .reset             (reset),
      .pps               (pps),
      .sync              (sync),
      .head              (head),
      .empty             (empty),
      .pop               (pop),
      .vita_time         (vita_time),
      .vita_time_lastpps (vita_time_lastpps)
   );

endmodule

`default_nettype wire

//--- dv/timekeeper_chk.sv
/*
 * assertions on the tracker pop handshake and free counter.
 * bound into every time_tracker instance.
 */

`timescale 1ns/1ns
`default_nettype none

module timekeeper_chk (
   input logic        clk,
   input logic        reset,
   input logic        pop,
   input logic        armed,
   input logic        time_event,
   input logic [63:0] vita_time
);

   // ==================================================
   // pop handshake
   // ==================================================

   // the tracker arms only through a pop.
   arm_after_pop: assert property (@(posedge clk) disable iff (reset)
      $rose(armed) |-> $past(pop))
      else $error("tracker armed without a pop on the previous cycle");

   // a pop always arms, so never two in a row.
   single_pop: assert property (@(posedge clk) disable iff (reset)
      pop |=> !pop)
      else $error("pop high on two cycles in a row");

   // ==================================================
   // counter
   // ==================================================

   // free count between loads.
   count_up: assert property (@(posedge clk) disable iff (reset)
      !time_event |=> (vita_time == $past(vita_time) + 64'd1))
      else $error("vita_time did not count up by one without a load");

endmodule

bind time_tracker timekeeper_chk chk_i (
   .clk        (clk),
   .reset      (reset),
   .pop        (pop),
   .armed      (armed),
   .time_event (time_event),
   .vita_time  (vita_time)
);

`default_nettype wire

//--- dv/timekeeper_tb.sv
/*
 * table-driven testbench for timekeeper_top, with a cycle reference model.
 * every output is compared each cycle after reset; the run stops at the first mismatch.
 */

`timescale 1ns/1ns
`default_nettype none

module timekeeper_tb;

   import timekeeper_pkg::*;

   typedef enum logic [1:0] {
      OP_WRITE = 2'd0,
      OP_PPS   = 2'd1,
      OP_SYNC  = 2'd2,
      OP_IDLE  = 2'd3
   } op_e;

   // one table row.
   // check_en compares the load count and overflow after the row.
   typedef struct packed {
      op_e         op;
      logic [7:0]  addr;
      logic [31:0] data;
      logic [15:0] count;
      logic        check_en;
      logic [7:0]  exp_loads;
      logic        exp_ovf;
   } entry_t;

   logic        clk;
   logic        reset;
   logic        pps;
   logic        sync;
   set_bus_t    set_bus;
   logic [63:0] vita_time;
   logic [63:0] vita_time_lastpps;
   logic        cmd_overflow;

   entry_t      stim[$];
   int          table_cycles = 0;
   int          cycle_count  = 0;
   int          cycle_limit  = 0;

   // ==================================================
   // reference model state
   // ==================================================

   logic [63:0] m_time    = '0;
   logic [63:0] m_lastpps = '0;
   logic        m_ovf     = 1'b0;
   logic [31:0] m_hi      = '0;
   logic [31:0] m_lo      = '0;
   logic        m_armed   = 1'b0;
   time_cmd_t   m_cmd;
   time_cmd_t   m_fifo[$];
   int          m_loads   = 0;
   // ctrl write to queue push takes two edges.
   logic        push_d1   = 1'b0;
   logic        push_d2   = 1'b0;
   time_cmd_t   push_cmd1;
   time_cmd_t   push_cmd2;
   // pps rise shows up two edges after it is sampled.
   logic        pps_prev  = 1'b0;
   logic        rise_d1   = 1'b0;
   logic        rise_d2   = 1'b0;

   timekeeper_top dut_i (
      .clk               (clk),
      .reset             (reset),
      .pps               (pps),
      .sync              (sync),
      .set_bus           (set_bus),
      .vita_time         (vita_time),
      .vita_time_lastpps (vita_time_lastpps),
      .cmd_overflow      (cmd_overflow)
   );

   always #20 clk = ~clk;

   // watchdog.
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("SOME TESTS FAILED");
         $fatal(1, "timeout");
      end
   end

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                  $time, name, actual, expected);
         $display("SOME TESTS FAILED");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // ==================================================
   // reference model, one call per clock edge
   // ==================================================

   // inputs are the values the dut samples on this edge.
   task automatic model_edge(input set_bus_t bus_s, input logic pps_s, input logic sync_s);
      logic        ev_pps;
      logic        load;
      logic        was_full;
      logic [63:0] next_time;
      ev_pps   = rise_d2;
      rise_d2  = rise_d1;
      rise_d1  = pps_s && !pps_prev;
      pps_prev = pps_s;
      // armed command fires on the event of its mode.
      load = 1'b0;
      if (m_armed) begin
         case (m_cmd.mode)
            MODE_NOW:  load = 1'b1;
            MODE_PPS:  load = ev_pps;
            MODE_SYNC: load = sync_s;
            default:   load = 1'b0;
         endcase
      end
      next_time = load ? m_cmd.time_value : m_time + 64'd1;
      if (ev_pps) begin
         m_lastpps = next_time;
      end
      m_time = next_time;
      if (load) begin
         m_loads++;
      end
      // fullness as it stands before this edge's pop.
      was_full = (m_fifo.size() == CMD_FIFO_DEPTH);
      if (m_armed) begin
         if (load) begin
            m_armed = 1'b0;
         end
      end else if (m_fifo.size() != 0) begin
         m_cmd   = m_fifo.pop_front();
         m_armed = 1'b1;
      end
      if (push_d2) begin
         if (was_full) begin
            m_ovf = 1'b1;
         end else begin
            m_fifo.push_back(push_cmd2);
         end
      end
      push_d2   = push_d1;
      push_cmd2 = push_cmd1;
      push_d1   = 1'b0;
      if (bus_s.stb) begin
         if (bus_s.addr == TIME_HI_ADDR) begin
            m_hi = bus_s.data;
         end else if (bus_s.addr == TIME_LO_ADDR) begin
            m_lo = bus_s.data;
         end else if (bus_s.addr == TIME_CTRL_ADDR && bus_s.data[1:0] != 2'd3) begin
            push_d1              = 1'b1;
            push_cmd1.mode       = time_mode_e'(bus_s.data[1:0]);
            push_cmd1.time_value = {m_hi, m_lo};
         end
      end
   endtask

   task automatic check_outputs();
      check_value("vita_time", vita_time, m_time);
      check_value("vita_time_lastpps", vita_time_lastpps, m_lastpps);
      check_value("cmd_overflow", 64'(cmd_overflow), 64'(m_ovf));
   endtask

   // drive on the rising edge, compare at the falling edge.
   task automatic run_cycle(input set_bus_t bus, input logic pps_v, input logic sync_v);
      @(posedge clk);
      model_edge(set_bus, pps, sync);
      set_bus <= bus;
      pps     <= pps_v;
      sync    <= sync_v;
      @(negedge clk);
      check_outputs();
   endtask

   task automatic apply_entry(input entry_t e);
      set_bus_t bus;
      bus = '0;
      case (e.op)
         OP_WRITE: begin
            bus.stb  = 1'b1;
            bus.addr = e.addr;
            bus.data = e.data;
            run_cycle(bus, 1'b0, 1'b0);
         end
         OP_PPS:  repeat (e.count) run_cycle(bus, 1'b1, 1'b0);
         OP_SYNC: run_cycle(bus, 1'b0, 1'b1);
         default: repeat (e.count) run_cycle(bus, 1'b0, 1'b0);
      endcase
      if (e.check_en) begin
         check_value("load count", 64'(m_loads), 64'(e.exp_loads));
         check_value("cmd_overflow", 64'(cmd_overflow), 64'(e.exp_ovf));
      end
   endtask

   // ==================================================
   // stimulus table
   // ==================================================

   function automatic void add_entry(input op_e op, input logic [7:0] addr,
                                     input logic [31:0] data, input int count,
                                     input logic check_en, input int loads, input logic ovf);
      stim.push_back('{op, addr, data, 16'(count), check_en, 8'(loads), ovf});
      table_cycles += count;
   endfunction

   // hi, lo, then ctrl.
   function automatic void add_set_time(input logic [63:0] value, input time_mode_e mode);
      add_entry(OP_WRITE, TIME_HI_ADDR, value[63:32], 1, 1'b0, 0, 1'b0);
      add_entry(OP_WRITE, TIME_LO_ADDR, value[31:0], 1, 1'b0, 0, 1'b0);
      add_entry(OP_WRITE, TIME_CTRL_ADDR, {30'd0, mode}, 1, 1'b0, 0, 1'b0);
   endfunction

   // random gap, then a three cycle pulse.
   function automatic void add_pps_pulse();
      add_entry(OP_IDLE, 8'd0, 32'd0, 5 + ($urandom() % 16), 1'b0, 0, 1'b0);
      add_entry(OP_PPS, 8'd0, 32'd0, 3, 1'b0, 0, 1'b0);
   endfunction

   function automatic logic [63:0] rand_time();
      logic [63:0] value;
      value[63:32] = $urandom();
      value[31:0]  = $urandom();
      return value;
   endfunction

   function automatic void build_table();
      add_entry(OP_IDLE, 8'd0, 32'd0, 10, 1'b1, 0, 1'b0);
      add_set_time(rand_time(), MODE_NOW);
      add_entry(OP_IDLE, 8'd0, 32'd0, 8, 1'b1, 1, 1'b0);
      add_set_time(rand_time(), MODE_PPS);
      add_pps_pulse();
      add_entry(OP_IDLE, 8'd0, 32'd0, 6, 1'b1, 2, 1'b0);
      // pps with nothing armed.
      add_pps_pulse();
      add_entry(OP_IDLE, 8'd0, 32'd0, 6, 1'b1, 2, 1'b0);
      add_set_time(rand_time(), MODE_SYNC);
      add_entry(OP_IDLE, 8'd0, 32'd0, 6, 1'b0, 0, 1'b0);
      add_entry(OP_SYNC, 8'd0, 32'd0, 1, 1'b0, 0, 1'b0);
      add_entry(OP_IDLE, 8'd0, 32'd0, 6, 1'b1, 3, 1'b0);
      // reserved mode, no command.
      add_entry(OP_WRITE, TIME_CTRL_ADDR, 32'd3, 1, 1'b0, 0, 1'b0);
      add_entry(OP_IDLE, 8'd0, 32'd0, 8, 1'b1, 3, 1'b0);
      // one armed plus a full queue, then one too many.
      for (int i = 0; i < CMD_FIFO_DEPTH + 1; i++) begin
         add_set_time(rand_time(), MODE_PPS);
      end
      add_entry(OP_IDLE, 8'd0, 32'd0, 4, 1'b1, 3, 1'b0);
      add_set_time(rand_time(), MODE_PPS);
      add_entry(OP_IDLE, 8'd0, 32'd0, 4, 1'b1, 3, 1'b1);
      for (int i = 0; i < CMD_FIFO_DEPTH + 2; i++) begin
         add_pps_pulse();
         add_entry(OP_IDLE, 8'd0, 32'd0, 6, 1'b1,
                   (i <= CMD_FIFO_DEPTH) ? 4 + i : 4 + CMD_FIFO_DEPTH, 1'b1);
      end
   endfunction

   initial begin
      clk     = 1'b0;
      reset   = 1'b1;
      pps     = 1'b0;
      sync    = 1'b0;
      set_bus = '0;
      void'($urandom(82228));
      build_table();
      cycle_limit = 2 * table_cycles + 100;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_outputs();
      foreach (stim[i]) begin
         apply_entry(stim[i]);
      end
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
logic/timekeeper_pkg.sv
logic/time_settings.sv
logic/time_cmd_fifo.sv
logic/time_tracker.sv
logic/timekeeper_top.sv
dv/timekeeper_chk.sv
dv/timekeeper_tb.sv
